// ==== hw/cop_pkg.sv ====
package cop_pkg;

    typedef logic [31:0] cop_word_t;     // Data word
    typedef logic [3:0]  cpr_addr_t;     // CPR index
    typedef logic [4:0]  gpr_addr_t;     // GPR index
    typedef logic [1:0]  cop_class_t;    // Instruction class
    typedef logic [2:0]  cop_subclass_t; // Operation within class
    typedef logic [2:0]  pack_width_t;   // Pack width code
    typedef logic [2:0]  cop_result_t;   // Result code back to CPU
    typedef logic [3:0]  byte_en_t;      // Per-byte write enable

    localparam int CPR_COUNT = 16;       // Number of CPRs

    // Encoding field positions, bit 0 upward
    localparam int FLD_OPCODE_LSB = 0;
    localparam int FLD_OPCODE_W   = 7;
    localparam int FLD_RD_LSB     = 7;
    localparam int FLD_RD_W       = 5;
    localparam int FLD_CRD_LSB    = 12;
    localparam int FLD_CRD_W      = 4;
    localparam int FLD_CRS1_LSB   = 16;
    localparam int FLD_CRS1_W     = 4;
    localparam int FLD_CRS2_LSB   = 20;
    localparam int FLD_CRS2_W     = 4;
    localparam int FLD_PW_LSB     = 24;
    localparam int FLD_PW_W       = 3;
    localparam int FLD_CLASS_LSB  = 27;
    localparam int FLD_CLASS_W    = 2;
    localparam int FLD_SCLASS_LSB = 29;
    localparam int FLD_SCLASS_W   = 3;

    localparam logic [6:0] COP_OPCODE = 7'b0001011; // custom-0 major opcode

    localparam cop_class_t ICLASS_MOVE    = 2'd0;
    localparam cop_class_t ICLASS_ARITH   = 2'd1;
    localparam cop_class_t ICLASS_BITWISE = 2'd2; // 3 is illegal

    localparam cop_subclass_t SCLASS_GPR2XCR = 3'd0; // GPR -> CPR
    localparam cop_subclass_t SCLASS_XCR2GPR = 3'd1; // CPR -> GPR
    localparam cop_subclass_t SCLASS_PADD    = 3'd0;
    localparam cop_subclass_t SCLASS_PSUB    = 3'd1;
    localparam cop_subclass_t SCLASS_AND     = 3'd0;
    localparam cop_subclass_t SCLASS_OR      = 3'd1;
    localparam cop_subclass_t SCLASS_XOR     = 3'd2;

    localparam pack_width_t PW_32 = 3'd0;
    localparam pack_width_t PW_16 = 3'd1;
    localparam pack_width_t PW_8  = 3'd2;
    localparam pack_width_t PW_4  = 3'd3;
    localparam pack_width_t PW_2  = 3'd4; // 5..7 illegal for arith

    localparam cop_result_t INSN_SUCCESS = 3'd0;
    localparam cop_result_t INSN_BAD_INS = 3'd1;

    typedef enum logic [1:0] {
        FSM_IDLE      = 2'd0, // Out of reset
        FSM_WAITING   = 2'd1, // Ack high, waiting for request
        FSM_EXECUTING = 2'd2, // Issue cycle
        FSM_FINISHED  = 2'd3  // Rsp high until CPU acks
    } cop_fsm_e;

    typedef struct packed {
        logic          exception; // Illegal encoding
        cop_class_t    iclass;
        cop_subclass_t subclass;
        pack_width_t   pw;
        gpr_addr_t     rd;
        cpr_addr_t     crd;
        cpr_addr_t     crs1;
        cpr_addr_t     crs2;
    } cop_decoded_t;

    typedef struct packed {
        byte_en_t  ben;   // Zero means no write
        cpr_addr_t addr;
        cop_word_t wdata;
    } cpr_write_t;

    typedef struct packed {
        logic        wen;    // GPR writeback enable
        gpr_addr_t   waddr;
        cop_word_t   wdata;
        cop_result_t result;
    } cop_wb_t;

endpackage

// ==== hw/cop_decode.sv ====
module cop_decode (
    input  cop_pkg::cop_word_t    insn_enc, // Registered encoding
    output cop_pkg::cop_decoded_t dec       // Fields plus illegal flag
);
    import cop_pkg::*;

    logic [FLD_OPCODE_W-1:0] opcode; // Major opcode
    logic                    legal;  // Class/subclass/pw combination valid

    assign opcode = insn_enc[FLD_OPCODE_LSB +: FLD_OPCODE_W];

    always_comb begin
        dec.iclass   = insn_enc[FLD_CLASS_LSB  +: FLD_CLASS_W];
        dec.subclass = insn_enc[FLD_SCLASS_LSB +: FLD_SCLASS_W];
        dec.pw       = insn_enc[FLD_PW_LSB     +: FLD_PW_W];
        dec.rd       = insn_enc[FLD_RD_LSB     +: FLD_RD_W];
        dec.crd      = insn_enc[FLD_CRD_LSB    +: FLD_CRD_W];
        dec.crs1     = insn_enc[FLD_CRS1_LSB   +: FLD_CRS1_W];
        dec.crs2     = insn_enc[FLD_CRS2_LSB   +: FLD_CRS2_W];

        legal = 1'b0;
        case (dec.iclass)
            ICLASS_MOVE: begin
                legal = (dec.subclass == SCLASS_GPR2XCR) ||
                        (dec.subclass == SCLASS_XCR2GPR);
            end
            ICLASS_ARITH: begin
                // pw only matters here, codes above PW_2 rejected
                legal = ((dec.subclass == SCLASS_PADD) ||
                         (dec.subclass == SCLASS_PSUB)) &&
                        (dec.pw <= PW_2);
            end
            ICLASS_BITWISE: begin
                legal = (dec.subclass == SCLASS_AND) ||
                        (dec.subclass == SCLASS_OR)  ||
                        (dec.subclass == SCLASS_XOR);
            end
            default: legal = 1'b0; // Class 3 reserved
        endcase

        dec.exception = (opcode != COP_OPCODE) || !legal;
    end

endmodule

// ==== hw/cop_cprs.sv ====
module cop_cprs (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  cop_pkg::cpr_addr_t  rs1_addr,  // Read port 1 address
    input  cop_pkg::cpr_addr_t  rs2_addr,  // Read port 2 address
    output cop_pkg::cop_word_t  rs1_rdata, // Async read data
    output cop_pkg::cop_word_t  rs2_rdata,
    input  cop_pkg::cpr_write_t wr         // Byte-enabled write port
);
    import cop_pkg::*;

    cop_word_t regs [CPR_COUNT]; // Register array

    assign rs1_rdata = regs[rs1_addr];
    assign rs2_rdata = regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < CPR_COUNT; i++) begin
                regs[i] <= '0; // All CPRs start at zero
            end
        end else begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (wr.ben[b]) begin
                    regs[wr.addr][8*b +: 8] <= wr.wdata[8*b +: 8]; // Per byte lane
                end
            end
        end
    end

endmodule

// ==== hw/cop_palu.sv ====
module cop_palu (
    input  logic                  issue,      // Execute strobe
    input  cop_pkg::cop_decoded_t dec,        // Decoded instruction
    input  cop_pkg::cop_word_t    gpr_rs1,    // Held GPR operand
    input  cop_pkg::cop_word_t    crs1_rdata, // CPR source 1
    input  cop_pkg::cop_word_t    crs2_rdata, // CPR source 2
    output cop_pkg::cpr_write_t   cpr_wr,     // CPR write request
    output cop_pkg::cop_wb_t      wb          // GPR writeback and result
);
    import cop_pkg::*;

    logic        sub;         // Packed subtract
    logic [15:0] lane_start;  // One bit per 2-bit slice, set at lane LSB
    cop_word_t   b_op;        // Second operand, inverted for subtract
    cop_word_t   arith_res;   // Packed add/sub result
    cop_word_t   cpr_wdata;   // Selected CPR write data
    logic        cpr_writes;  // Instruction targets a CPR
    logic        gpr_writes;  // Instruction targets a GPR
    logic        do_gpr;      // GPR write survives exception check

    assign sub  = (dec.subclass == SCLASS_PSUB);
    assign b_op = sub ? ~crs2_rdata : crs2_rdata;

    // Carry chain is restarted at every lane boundary
    always_comb begin
        case (dec.pw)
            PW_16:   lane_start = 16'h0101;
            PW_8:    lane_start = 16'h1111;
            PW_4:    lane_start = 16'h5555;
            PW_2:    lane_start = 16'hffff;
            default: lane_start = 16'h0001; // PW_32, one lane
        endcase
    end

    always_comb begin
        logic carry; // Ripple between 2-bit slices
        carry = sub;
        for (int i = 0; i < 16; i++) begin
            if (lane_start[i]) begin
                carry = sub; // +1 per lane completes two's complement
            end
            {carry, arith_res[2*i +: 2]} = {1'b0, crs1_rdata[2*i +: 2]} +
                                           {1'b0, b_op[2*i +: 2]} + carry;
        end
    end

    always_comb begin
        cpr_wdata  = '0;
        cpr_writes = 1'b0;
        gpr_writes = 1'b0;
        case (dec.iclass)
            ICLASS_MOVE: begin
                if (dec.subclass == SCLASS_GPR2XCR) begin
                    cpr_writes = 1'b1;
                    cpr_wdata  = gpr_rs1;
                end else begin
                    gpr_writes = 1'b1; // XCR2GPR, data from crs1
                end
            end
            ICLASS_ARITH: begin
                cpr_writes = 1'b1;
                cpr_wdata  = arith_res;
            end
            ICLASS_BITWISE: begin
                cpr_writes = 1'b1;
                case (dec.subclass)
                    SCLASS_AND: cpr_wdata = crs1_rdata & crs2_rdata;
                    SCLASS_OR:  cpr_wdata = crs1_rdata | crs2_rdata;
                    default:    cpr_wdata = crs1_rdata ^ crs2_rdata;
                endcase
            end
            default: cpr_writes = 1'b0; // Reserved, flagged by decode
        endcase
    end

    assign do_gpr = gpr_writes & ~dec.exception;

    assign cpr_wr.ben   = {$bits(byte_en_t){issue & cpr_writes & ~dec.exception}};
    assign cpr_wr.addr  = dec.crd;
    assign cpr_wr.wdata = cpr_wdata;

    assign wb.wen    = do_gpr;
    assign wb.waddr  = dec.rd;
    assign wb.wdata  = do_gpr ? crs1_rdata : '0;   // Zero unless CPR->GPR
    assign wb.result = dec.exception ? INSN_BAD_INS : INSN_SUCCESS;

endmodule

// ==== hw/cop_insn_ctrl.sv ====
module cop_insn_ctrl (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cpu_insn_req, // CPU request
    input  cop_pkg::cop_word_t   cpu_insn_enc, // Valid with req
    input  cop_pkg::cop_word_t   cpu_rs1,      // Valid with req
    input  logic                 cpu_insn_ack, // CPU takes response
    output logic                 cop_insn_ack, // Registered accept
    output logic                 cop_insn_rsp, // Registered response
    output cop_pkg::cop_word_t   insn_enc,     // Held encoding
    output cop_pkg::cop_word_t   gpr_rs1,      // Held rs1
    output logic                 issue,        // High in FSM_EXECUTING
    input  cop_pkg::cop_wb_t     wb,           // Writeback from PALU
    output logic                 cop_wen,
    output cop_pkg::gpr_addr_t   cop_waddr,
    output cop_pkg::cop_word_t   cop_wdata,
    output cop_pkg::cop_result_t cop_result
);
    import cop_pkg::*;

    cop_fsm_e state;     // Current state
    cop_fsm_e state_n;   // Next state
    logic     ack_n;     // Next cop_insn_ack
    logic     rsp_n;     // Next cop_insn_rsp
    logic     accept;    // Handshake in
    logic     retire;    // Handshake out
    cop_wb_t  wb_q;      // Held writeback, stable under back-pressure

    assign accept = cpu_insn_req & cop_insn_ack;
    assign retire = cop_insn_rsp & cpu_insn_ack;
    assign issue  = (state == FSM_EXECUTING);

    always_comb begin
        state_n = state; // Hold by default
        ack_n   = 1'b0;
        rsp_n   = 1'b0;
        case (state)
            FSM_IDLE: begin
                state_n = FSM_WAITING;     // Ack one cycle after reset
                ack_n   = 1'b1;
            end
            FSM_WAITING: begin
                if (accept) begin
                    state_n = FSM_EXECUTING; // Ack drops after accept
                end else begin
                    ack_n = 1'b1;
                end
            end
            FSM_EXECUTING: begin
                state_n = FSM_FINISHED;    // Fixed single execute cycle
                rsp_n   = 1'b1;
            end
            FSM_FINISHED: begin
                if (retire) begin
                    state_n = FSM_WAITING;   // Ready for next at once
                    ack_n   = 1'b1;
                end else begin
                    rsp_n = 1'b1;            // Back-pressure, hold rsp
                end
            end
            default: state_n = FSM_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= FSM_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            state        <= state_n;
            cop_insn_ack <= ack_n;
            cop_insn_rsp <= rsp_n;
        end
    end

    // Operand capture on accept
    always_ff @(posedge g_clk) begin
        if (accept) begin
            insn_enc <= cpu_insn_enc;
            gpr_rs1  <= cpu_rs1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wb_q <= '0;           // wen low, result success
        end else if (issue) begin
            wb_q <= wb;           // Same edge as CPR write
        end
    end

    assign cop_wen    = wb_q.wen;
    assign cop_waddr  = wb_q.waddr;
    assign cop_wdata  = wb_q.wdata;
    assign cop_result = wb_q.result;

endmodule

// ==== hw/cop_top.sv ====
module cop_top (
    input  logic                 g_clk,        // Global clock
    input  logic                 g_resetn,     // Sync active low reset
    input  logic                 cpu_insn_req, // Instruction request
    input  cop_pkg::cop_word_t   cpu_insn_enc, // Encoded instruction
    input  cop_pkg::cop_word_t   cpu_rs1,      // GPR rs1 value
    input  logic                 cpu_insn_ack, // Response taken by CPU
    output logic                 cop_insn_ack, // Request accepted
    output logic                 cop_insn_rsp, // Instruction finished
    output logic                 cop_wen,      // GPR write enable
    output cop_pkg::gpr_addr_t   cop_waddr,    // GPR write address
    output cop_pkg::cop_word_t   cop_wdata,    // GPR write data
    output cop_pkg::cop_result_t cop_result    // Result code
);
    import cop_pkg::*;

    cop_word_t    insn_enc;   // Registered encoding
    cop_word_t    gpr_rs1;    // Registered rs1
    logic         issue;      // One-cycle execute strobe
    cop_decoded_t dec;        // Decoded fields
    cop_word_t    crs1_rdata; // CPR port 1 data
    cop_word_t    crs2_rdata; // CPR port 2 data
    cpr_write_t   cpr_wr;     // CPR write port
    cop_wb_t      wb;         // Next GPR writeback

    cop_insn_ctrl u_ctrl (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .insn_enc     (insn_enc),
        .gpr_rs1      (gpr_rs1),
        .issue        (issue),
        .wb           (wb),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    cop_decode u_decode (
        .insn_enc (insn_enc),
        .dec      (dec)
    );

    cop_cprs u_cprs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rs1_addr  (dec.crs1),   // Read addresses straight from decode
        .rs2_addr  (dec.crs2),
        .rs1_rdata (crs1_rdata),
        .rs2_rdata (crs2_rdata),
        .wr        (cpr_wr)
    );

    cop_palu u_palu (
        .issue      (issue),
        .dec        (dec),
        .gpr_rs1    (gpr_rs1),
        .crs1_rdata (crs1_rdata),
        .crs2_rdata (crs2_rdata),
        .cpr_wr     (cpr_wr),
        .wb         (wb)
    );

endmodule

// ==== testbench/tb_cop_model.svh ====
`ifndef TB_COP_MODEL_SVH
`define TB_COP_MODEL_SVH

cop_word_t model_cprs [16]; // Expected CPR contents
int        check_count;     // Compares done
int        error_count;     // Compares failed

task automatic clear_model();
    for (int i = 0; i < 16; i++) begin
        model_cprs[i] = '0; // Matches DUT reset
    end
endtask

// Lane-by-lane modular add or subtract, width in bits
function automatic cop_word_t packed_arith(cop_word_t a, cop_word_t b, int width, bit sub);
    cop_word_t   res;
    logic [32:0] mask;
    logic [32:0] la;
    logic [32:0] lb;
    logic [32:0] lane;
    res  = '0;
    mask = (33'd1 << width) - 33'd1;
    for (int lsb = 0; lsb < 32; lsb += width) begin
        la   = {1'b0, a >> lsb} & mask;
        lb   = {1'b0, b >> lsb} & mask;
        lane = (sub ? la - lb : la + lb) & mask; // Wraps inside the lane
        res  = res | cop_word_t'(lane << lsb);
    end
    return res;
endfunction

function automatic cop_wb_t ref_exec(cop_word_t enc, cop_word_t rs1);
    cop_wb_t       res_wb;
    cop_class_t    cls;
    cop_subclass_t sc;
    pack_width_t   pw;
    cpr_addr_t     crd;
    cop_word_t     a;
    cop_word_t     b;
    logic          legal;
    cls = enc[FLD_CLASS_LSB +: FLD_CLASS_W];
    sc  = enc[FLD_SCLASS_LSB +: FLD_SCLASS_W];
    pw  = enc[FLD_PW_LSB +: FLD_PW_W];
    crd = enc[FLD_CRD_LSB +: FLD_CRD_W];
    a   = model_cprs[enc[FLD_CRS1_LSB +: FLD_CRS1_W]];
    b   = model_cprs[enc[FLD_CRS2_LSB +: FLD_CRS2_W]];
    res_wb        = '0;
    res_wb.waddr  = enc[FLD_RD_LSB +: FLD_RD_W];
    res_wb.result = INSN_SUCCESS;
    legal = (enc[FLD_OPCODE_LSB +: FLD_OPCODE_W] == COP_OPCODE);
    if (cls == ICLASS_MOVE) begin
        legal = legal && (sc == SCLASS_GPR2XCR || sc == SCLASS_XCR2GPR);
    end else if (cls == ICLASS_ARITH) begin
        legal = legal && (sc == SCLASS_PADD || sc == SCLASS_PSUB) && (pw <= PW_2);
    end else if (cls == ICLASS_BITWISE) begin
        legal = legal && (sc <= SCLASS_XOR);
    end else begin
        legal = 1'b0; // Reserved class
    end
    if (!legal) begin
        res_wb.result = INSN_BAD_INS; // No register changes
        return res_wb;
    end
    case (cls)
        ICLASS_MOVE: begin
            if (sc == SCLASS_GPR2XCR) begin
                model_cprs[crd] = rs1;
            end else begin
                res_wb.wen   = 1'b1;
                res_wb.wdata = a;
            end
        end
        ICLASS_ARITH: model_cprs[crd] = packed_arith(a, b, 32 >> pw, sc == SCLASS_PSUB);
        default: begin
            if (sc == SCLASS_AND) begin
                model_cprs[crd] = a & b;
            end else if (sc == SCLASS_OR) begin
                model_cprs[crd] = a | b;
            end else begin
                model_cprs[crd] = a ^ b;
            end
        end
    endcase
    return res_wb;
endfunction

task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("error at %0t: %s, got %h expected %h", $time, what, got, want);
    end
endtask

`endif

// ==== testbench/tb_cop_top.sv ====
module tb_cop_top;
    import cop_pkg::*;

    localparam int WAIT_LIMIT = 50; // Cycles before a wait gives up

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        cpu_insn_req;
    cop_word_t   cpu_insn_enc;
    cop_word_t   cpu_rs1;
    logic        cpu_insn_ack;
    logic        cop_insn_ack;
    logic        cop_insn_rsp;
    logic        cop_wen;
    gpr_addr_t   cop_waddr;
    cop_word_t   cop_wdata;
    cop_result_t cop_result;
    cop_wb_t     exp_q [$];    // Expected writebacks, issue order
    cop_wb_t     held;         // Outputs seen under back-pressure
    logic        hold_seen;    // Last edge was rsp high, ack low
    logic [1:0]  accept_pipe;  // Accept history for latency check

    `include "tb_cop_model.svh"

    always #10 g_clk = ~g_clk; // 20 unit period

    cop_top UUT (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Returns at the first edge where ack is high
    task automatic wait_for_ack();
        int waited;
        waited = 0;
        @(posedge g_clk);
        while (!cop_insn_ack) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: coprocessor never raised ack");
            end
            @(posedge g_clk);
        end
    endtask

    task automatic run_insn(input cop_word_t enc, input cop_word_t rs1);
        int stall;
        int waited;
        cpu_insn_req <= 1'b1;
        cpu_insn_enc <= enc;
        cpu_rs1      <= rs1;
        wait_for_ack();                      // Accept edge
        cpu_insn_req <= 1'b0;
        exp_q.push_back(ref_exec(enc, rs1)); // Model steps in issue order
        waited = 0;
        @(posedge g_clk);
        while (!cop_insn_rsp) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: coprocessor never raised rsp");
            end
            @(posedge g_clk);
        end
        stall = $urandom_range(0, 5);        // Back-pressure
        repeat (stall) @(posedge g_clk);
        cpu_insn_ack <= 1'b1;
        @(posedge g_clk);                    // Retiring edge
        cpu_insn_ack <= 1'b0;
    endtask

    function automatic cop_word_t encode_insn(cop_class_t cls, cop_subclass_t sc,
                                              pack_width_t pw, gpr_addr_t rd,
                                              cpr_addr_t crd, cpr_addr_t crs1,
                                              cpr_addr_t crs2);
        cop_word_t enc;
        enc = '0;
        enc[FLD_OPCODE_LSB +: FLD_OPCODE_W] = COP_OPCODE;
        enc[FLD_RD_LSB +: FLD_RD_W]         = rd;
        enc[FLD_CRD_LSB +: FLD_CRD_W]       = crd;
        enc[FLD_CRS1_LSB +: FLD_CRS1_W]     = crs1;
        enc[FLD_CRS2_LSB +: FLD_CRS2_W]     = crs2;
        enc[FLD_PW_LSB +: FLD_PW_W]         = pw;
        enc[FLD_CLASS_LSB +: FLD_CLASS_W]   = cls;
        enc[FLD_SCLASS_LSB +: FLD_SCLASS_W] = sc;
        return enc;
    endfunction

    function automatic cop_word_t illegal_insn();
        cop_class_t    cls;
        cop_subclass_t sc;
        pack_width_t   pw;
        cop_word_t     enc;
        int            kind;
        cls  = cop_class_t'($urandom_range(0, 2));
        sc   = '0;
        pw   = PW_32;
        kind = $urandom_range(0, 3);
        case (kind)
            0: sc = '0;                                   // Opcode broken below
            1: begin
                cls = 2'd3;                               // Reserved class
                sc  = cop_subclass_t'($urandom_range(0, 7));
            end
            2: begin
                if (cls == ICLASS_BITWISE) begin
                    sc = cop_subclass_t'($urandom_range(3, 7));
                end else begin
                    sc = cop_subclass_t'($urandom_range(2, 7));
                end
            end
            default: begin
                cls = ICLASS_ARITH;                       // Bad pack width
                sc  = cop_subclass_t'($urandom_range(0, 1));
                pw  = pack_width_t'($urandom_range(5, 7));
            end
        endcase
        enc = encode_insn(cls, sc, pw, gpr_addr_t'($urandom), cpr_addr_t'($urandom),
                          cpr_addr_t'($urandom), cpr_addr_t'($urandom));
        if (kind == 0) begin
            enc[FLD_OPCODE_LSB +: FLD_OPCODE_W] = COP_OPCODE ^ 7'($urandom_range(1, 127));
        end
        return enc;
    endfunction

    task automatic read_back(input int r);
        run_insn(encode_insn(ICLASS_MOVE, SCLASS_XCR2GPR, PW_32,
                             gpr_addr_t'($urandom_range(1, 31)), '0, cpr_addr_t'(r), '0),
                 $urandom);
    endtask

    // Compare process, one expected entry per retire
    always @(posedge g_clk) begin : compare_retire
        cop_wb_t want;
        if (g_resetn === 1'b1 && cop_insn_rsp && cpu_insn_ack) begin
            check_value(exp_q.size(), 1, "instructions outstanding at retire");
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                check_value(cop_result, want.result, "result code");
                check_value(cop_wen, want.wen, "gpr write enable");
                if (want.wen) begin
                    check_value(cop_waddr, want.waddr, "gpr write address");
                    check_value(cop_wdata, want.wdata, "gpr write data");
                end
            end
        end
    end

    // Handshake rules under back-pressure
    always @(posedge g_clk) begin : watch_handshake
        if (g_resetn === 1'b1) begin
            if (hold_seen) begin
                check_value(cop_insn_rsp, 1, "rsp dropped before retire");
                check_value({cop_wen, cop_waddr, cop_wdata, cop_result}, held,
                            "outputs changed under back-pressure");
            end
            if (cop_insn_rsp) begin
                check_value(cop_insn_ack, 0, "ack high while rsp pending");
            end
            if (accept_pipe[0]) begin
                check_value(cop_insn_rsp, 0, "rsp too early after accept");
                check_value(cop_insn_ack, 0, "ack high in execute cycle");
            end
            if (accept_pipe[1]) begin
                check_value(cop_insn_rsp, 1, "rsp missing one cycle after accept");
            end
            hold_seen   <= cop_insn_rsp && !cpu_insn_ack;
            held        <= {cop_wen, cop_waddr, cop_wdata, cop_result};
            accept_pipe <= {accept_pipe[0], cpu_insn_req && cop_insn_ack};
        end else begin
            hold_seen   <= 1'b0;
            accept_pipe <= '0;
        end
    end

    initial begin
        cpr_addr_t dst; // Destination under test
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        check_count  = 0;
        error_count  = 0;
        void'($urandom(32'h444f));           // Seed once
        clear_model();
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);
        check_value(cop_insn_ack, 0, "ack after reset");
        check_value(cop_insn_rsp, 0, "rsp after reset");
        check_value(cop_wen, 0, "wen after reset");
        check_value(cop_result, INSN_SUCCESS, "result after reset");
        wait_for_ack();

        for (int r = 0; r < 16; r++) begin   // Fill every CPR
            run_insn(encode_insn(ICLASS_MOVE, SCLASS_GPR2XCR, PW_32, '0,
                                 cpr_addr_t'(r), '0, '0), $urandom);
        end
        for (int r = 0; r < 16; r++) begin
            read_back(r);
        end

        for (int p = 0; p < 5; p++) begin    // All pack widths, add and sub
            for (int s = 0; s < 2; s++) begin
                repeat (4) begin
                    dst = cpr_addr_t'($urandom);
                    run_insn(encode_insn(ICLASS_ARITH, cop_subclass_t'(s), pack_width_t'(p),
                                         '0, dst, cpr_addr_t'($urandom),
                                         cpr_addr_t'($urandom)), $urandom);
                    read_back(dst);          // Result just written
                end
            end
        end

        for (int s = 0; s < 3; s++) begin    // AND, OR, XOR
            repeat (4) begin
                dst = cpr_addr_t'($urandom);
                run_insn(encode_insn(ICLASS_BITWISE, cop_subclass_t'(s), PW_32, '0,
                                     dst, cpr_addr_t'($urandom),
                                     cpr_addr_t'($urandom)), $urandom);
                read_back(dst);
            end
        end

        repeat (16) begin                    // Illegal encodings
            run_insn(illegal_insn(), $urandom);
        end
        for (int r = 0; r < 16; r++) begin   // Nothing may have changed
            read_back(r);
        end

        @(posedge g_clk);                    // Let the last compare run
        check_value(exp_q.size(), 0, "instructions never retired");
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+testbench
hw/cop_pkg.sv
hw/cop_decode.sv
hw/cop_cprs.sv
hw/cop_palu.sv
hw/cop_insn_ctrl.sv
hw/cop_top.sv
testbench/tb_cop_top.sv

// ==== Bender.yml ====
package:
  name: cop

sources:
  - files:
      - hw/cop_pkg.sv
      - hw/cop_decode.sv
      - hw/cop_cprs.sv
      - hw/cop_palu.sv
      - hw/cop_insn_ctrl.sv
      - hw/cop_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_cop_top.sv
